/* build.f */
+incdir+logic
logic/alu_types_pkg.sv
logic/fp_types_pkg.sv
logic/int_unit.sv
logic/fp_compare.sv
logic/fp_convert.sv
logic/latency_ctrl.sv
logic/alu.sv
verification/alu_properties.sv
verification/alu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = alu_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = SOME TESTS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/alu_tb.sv */
`timescale 1ns/10ps

module alu_tb
    import alu_types_pkg::*;
    import fp_types_pkg::*;
();

    localparam int num_ops  = 2000;
    localparam int max_wait = 64;

    // weighted toward the multi-cycle ops
    // the last four entries are unlisted codes
    localparam alu_op_t op_table [32] = '{
        op_add,   op_sub,   op_fneg,  op_fabs,  op_feq,   op_flt,   op_fle,   op_fmvwx,
        op_fmvxw, op_fmv,   op_itof,  op_ftoi,  op_addi,  op_slli,  op_srai,  op_srl,
        op_slt,   op_sltu,  op_xor,   op_and,   op_or,    op_lui,   op_itof,  op_ftoi,
        op_flt,   op_fle,   op_itof,  op_ftoi,  6'b000010, 6'b010000, 6'b101001, 6'b111111
    };

    logic        clk;
    logic        rst;
    logic        stall;
    word_t       op1;
    word_t       op2;
    alu_op_t     aluctl;
    word_t       wb_res;
    word_t       alu_fwd;
    logic        alu_stall;

    logic [31:0] rng_state;
    word_t       wb_exp;

    alu i_alu (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .op1       (op1),
        .op2       (op2),
        .aluctl    (aluctl),
        .wb_res    (wb_res),
        .alu_fwd   (alu_fwd),
        .alu_stall (alu_stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic word_t special_value(logic [3:0] idx);
        case (idx)
            4'd0:    return 32'h0000_0000;
            4'd1:    return 32'h8000_0000;
            4'd2:    return 32'h7f80_0000;
            4'd3:    return 32'hff80_0000;
            4'd4:    return fp_qnan;
            4'd5:    return 32'hff81_2345;
            // around 2^31 and -2^31
            4'd6:    return 32'h4f00_0000;
            4'd7:    return 32'hcf00_0000;
            4'd8:    return 32'h4eff_ffff;
            4'd9:    return 32'hcf00_0001;
            4'd10:   return 32'h3f80_0000;
            4'd11:   return 32'hbf7f_ffff;
            4'd12:   return 32'h7fff_ffff;
            4'd13:   return 32'h0000_0001;
            4'd14:   return 32'h8000_0001;
            default: return 32'h3f00_0000;
        endcase
    endfunction

    function automatic word_t pick_operand();
        logic [31:0] r;
        logic [31:0] s;
        fp_exp_t     e;
        r = next_random();
        s = next_random();
        // exponent from one up to 2^31
        e = fp_exp_bias + fp_exp_t'(s[4:0]);
        case (r[2:0])
            3'd0:    return special_value(s[3:0]);
            3'd1:    return {s[31], e, s[22:0]};
            3'd2:    return {{24{s[7]}}, s[7:0]};
            default: return s;
        endcase
    endfunction

    function automatic logic pick_stall();
        logic [31:0] r;
        r = next_random();
        return r[1:0] == 2'b00;
    endfunction

    function automatic int latency_of(alu_op_t op);
        case (op)
            op_flt, op_fle, op_ftoi: return 1;
            op_itof:                 return 2;
            default:                 return 0;
        endcase
    endfunction

    function automatic logic is_nan(word_t x);
        fp_exp_t  e;
        fp_frac_t f;
        e = x[30:23];
        f = x[22:0];
        return (e == 8'hff) && (f != '0);
    endfunction

    // signed-magnitude view where both zeros map to 0
    function automatic longint ordered_key(word_t x);
        longint mag;
        mag = longint'(x[30:0]);
        return x[31] ? -mag : mag;
    endfunction

    function automatic word_t compare_model(alu_op_t op, word_t a, word_t b);
        longint ka;
        longint kb;
        logic   res;
        if (is_nan(a) || is_nan(b)) begin
            return '0;
        end
        ka = ordered_key(a);
        kb = ordered_key(b);
        case (op)
            op_feq:  res = (ka == kb);
            op_flt:  res = (ka < kb);
            default: res = (ka <= kb);
        endcase
        return {31'd0, res};
    endfunction

    // the integer is exact as a double
    // its 52-bit fraction is rounded to nearest even
    function automatic word_t itof_model(word_t x);
        logic [63:0] d;
        logic [7:0]  e;
        logic [22:0] f;
        logic [28:0] rest;
        logic        up;
        d = $realtobits($itor($signed(x)));
        if (d[62:0] == '0) begin
            return '0;
        end
        e    = 8'(d[62:52] - 11'd896);
        f    = d[51:29];
        rest = d[28:0];
        up   = (rest > 29'h1000_0000) || (rest == 29'h1000_0000 && f[0]);
        return {d[63], {e, f} + 31'(up)};
    endfunction

    function automatic word_t ftoi_model(word_t x);
        fp_exp_t e;
        int      unb;
        longint  mant;
        longint  mag;
        e = x[30:23];
        if (is_nan(x)) begin
            return 32'h7fff_ffff;
        end
        unb = int'(e) - int'(fp_exp_bias);
        if (unb < 0) begin
            return '0;
        end
        // also covers infinities
        if (unb >= 31) begin
            return x[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end
        mant = longint'({1'b1, x[22:0]});
        if (unb >= 23) begin
            mag = mant << (unb - 23);
        end else begin
            mag = mant >> (23 - unb);
        end
        if (x[31]) begin
            mag = -mag;
        end
        return word_t'(mag);
    endfunction

    function automatic word_t expected_result(alu_op_t op, word_t a, word_t b);
        case (op)
            op_add, op_addi:           return a + b;
            op_sub:                    return a - b;
            op_slli:                   return a << b[4:0];
            op_srl:                    return a >> b[4:0];
            op_srai:                   return word_t'($signed(a) >>> b[4:0]);
            op_slt:                    return {31'd0, $signed(a) < $signed(b)};
            op_sltu:                   return {31'd0, a < b};
            op_xor:                    return a ^ b;
            op_and:                    return a & b;
            op_or:                     return a | b;
            op_lui:                    return b;
            op_fneg:                   return a ^ 32'h8000_0000;
            op_fabs:                   return a & 32'h7fff_ffff;
            op_fmvwx, op_fmvxw, op_fmv: return a;
            op_feq, op_flt, op_fle:    return compare_model(op, a, b);
            op_itof:                   return itof_model(a);
            op_ftoi:                   return ftoi_model(a);
            default:                   return '0;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h (aluctl %h, op1 %h, op2 %h)",
                     name, got, expected, aluctl, op1, op2);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h (aluctl %h)", name, got, expected, aluctl);
            stop_with_failure();
        end
    endtask

    // present one op and hold it until the write-back register takes it
    task automatic run_op(input alu_op_t op, input word_t a, input word_t b);
        word_t expected;
        int    lat;
        int    cycle;
        logic  accepted;
        expected = expected_result(op, a, b);
        lat      = latency_of(op);
        cycle    = 0;
        accepted = 1'b0;
        @(posedge clk);
        aluctl <= op;
        op1    <= a;
        op2    <= b;
        stall  <= pick_stall();
        while (!accepted) begin
            if (cycle > max_wait) begin
                $display("Timeout: operation %h not accepted within %0d cycles", op, max_wait);
                stop_with_failure();
            end
            @(negedge clk);
            check_flag("alu_stall", alu_stall, cycle < lat);
            check_word("wb_res", wb_res, wb_exp);
            if (cycle >= lat) begin
                check_word("alu_fwd", alu_fwd, expected);
                accepted = !stall;
            end
            if (!accepted) begin
                @(posedge clk);
                stall <= pick_stall();
                cycle++;
            end
        end
        wb_exp = expected;
    endtask

    initial begin
        logic [31:0] pick;
        word_t       a;
        word_t       b;
        rng_state = 32'h5939;
        wb_exp    = '0;
        rst       = 1'b1;
        stall     = 1'b0;
        op1       = '0;
        op2       = '0;
        aluctl    = op_add;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word("wb_res", wb_res, '0);
        check_flag("alu_stall", alu_stall, 1'b0);

        for (int n = 0; n < num_ops; n++) begin
            pick = next_random();
            a    = pick_operand();
            // equal and sign-flipped pairs exercise the compares
            case (pick[2:0])
                3'd0:    b = a;
                3'd1:    b = a ^ 32'h8000_0000;
                default: b = pick_operand();
            endcase
            run_op(op_table[pick[7:3]], a, b);
        end

        // last accept edge before reading the write-back register
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_word("wb_res", wb_res, wb_exp);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verification/alu_properties.sv */
`timescale 1ns/10ps

module alu_properties
    import alu_types_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input alu_op_t op,
    input logic    stall,
    input logic    busy,
    input logic    accept
);

    lat_class_t lat;

    always_comb begin
        case (op)
            op_flt, op_fle, op_ftoi: lat = lat_one;
            op_itof:                 lat = lat_two;
            default:                 lat = lat_zero;
        endcase
    end

    // write-back load only once the result is ready
    accept_not_busy: assert property (@(posedge clk) disable iff (rst) !(accept && busy))
        else $error("accept raised while busy");

    accept_not_stalled: assert property (@(posedge clk) disable iff (rst) stall |-> !accept)
        else $error("accept raised during external stall");

    // zero-latency ops never hold the pipeline
    busy_has_class: assert property (@(posedge clk) disable iff (rst) busy |-> lat != lat_zero)
        else $error("busy raised for a zero-latency opcode");

    // itof is the longest at two cycles
    busy_bounded: assert property (@(posedge clk) disable iff (rst)
        (busy && $past(busy)) |=> !busy)
        else $error("busy lasted longer than two cycles");

endmodule

bind alu alu_properties i_alu_properties (
    .clk    (clk),
    .rst    (rst),
    .op     (aluctl),
    .stall  (stall),
    .busy   (alu_stall),
    .accept (accept)
);

/* logic/alu.sv */
`timescale 1ns/10ps

`include "alu_config.svh"

module alu
    import alu_types_pkg::*;
    import fp_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  word_t   op1,
    input  word_t   op2,
    input  alu_op_t aluctl,
    output word_t   wb_res,
    output word_t   alu_fwd,
    output logic    alu_stall
);

    word_t    int_res;
    word_t    feq_res;
    word_t    flt_res;
    word_t    fle_res;
    word_t    itof_res;
    word_t    ftoi_res;
    word_t    fneg_res;
    word_t    fabs_res;
    fp_sign_t op1_sign;
    fp_exp_t  op1_exp;
    fp_frac_t op1_frac;
    logic     accept;

    int_unit i_int_unit (
        .op1 (op1),
        .op2 (op2),
        .op  (aluctl),
        .res (int_res)
    );

    fp_compare i_fp_compare (
        .clk (clk),
        .rst (rst),
        .op1 (op1),
        .op2 (op2),
        .feq (feq_res),
        .flt (flt_res),
        .fle (fle_res)
    );

    fp_convert i_fp_convert (
        .clk  (clk),
        .rst  (rst),
        .op1  (op1),
        .itof (itof_res),
        .ftoi (ftoi_res)
    );

    latency_ctrl i_latency_ctrl (
        .clk    (clk),
        .rst    (rst),
        .op     (aluctl),
        .stall  (stall),
        .busy   (alu_stall),
        .accept (accept)
    );

    // sign ops touch only bit 31
    assign op1_sign = op1[`ALU_XLEN-1];
    assign op1_exp  = op1[30:23];
    assign op1_frac = op1[22:0];
    assign fneg_res = {~op1_sign, op1_exp, op1_frac};
    assign fabs_res = {1'b0, op1_exp, op1_frac};

    always_comb begin
        case (aluctl)
            op_fneg:                     alu_fwd = fneg_res;
            op_fabs:                     alu_fwd = fabs_res;
            op_feq:                      alu_fwd = feq_res;
            op_flt:                      alu_fwd = flt_res;
            op_fle:                      alu_fwd = fle_res;
            // raw bit moves between register files
            op_fmvwx, op_fmvxw, op_fmv:  alu_fwd = op1;
            op_itof:                     alu_fwd = itof_res;
            op_ftoi:                     alu_fwd = ftoi_res;
            // int_unit gives zero for unlisted codes
            default:                     alu_fwd = int_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_res <= '0;
        end else if (accept) begin
            wb_res <= alu_fwd;
        end
    end

endmodule

/* logic/latency_ctrl.sv */
`timescale 1ns/10ps

module latency_ctrl
    import alu_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  alu_op_t op,
    input  logic    stall,
    output logic    busy,
    output logic    accept
);

    typedef enum logic [1:0] {
        st_idle,
        st_count,
        st_done
    } ctrl_state_t;

    lat_class_t  lat;
    ctrl_state_t state;
    ctrl_state_t state_next;
    logic [1:0]  cnt;
    logic [1:0]  cnt_next;

    always_comb begin
        case (op)
            op_flt, op_fle, op_ftoi: lat = lat_one;
            op_itof:                 lat = lat_two;
            default:                 lat = lat_zero;
        endcase
    end

    always_comb begin
        state_next = state;
        cnt_next   = cnt;
        busy       = 1'b0;
        accept     = 1'b0;
        case (state)
            st_idle: begin
                if (lat == lat_zero) begin
                    accept = ~stall;
                    if (stall) begin
                        state_next = st_done;
                    end
                end else begin
                    busy     = 1'b1;
                    // cycles still to wait after this one
                    cnt_next = lat - 2'd1;
                    if (lat == lat_one) begin
                        state_next = st_done;
                    end else begin
                        state_next = st_count;
                    end
                end
            end
            st_count: begin
                busy     = 1'b1;
                cnt_next = cnt - 2'd1;
                if (cnt == 2'd1) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                // result ready, wait out the external stall
                accept = ~stall;
                if (!stall) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            state <= state_next;
            cnt   <= cnt_next;
        end
    end

endmodule

/* logic/fp_convert.sv */
`timescale 1ns/10ps

module fp_convert
    import alu_types_pkg::*;
    import fp_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t op1,
    output word_t itof,
    output word_t ftoi
);

    localparam word_t   int_max     = 32'h7fff_ffff;
    localparam word_t   int_min     = 32'h8000_0000;
    // biased exponent of 2^31
    localparam fp_exp_t exp_int_top = fp_exp_bias + 8'd31;

    // itof stage one
    fp_sign_t    in_sign;
    word_t       in_mag;
    logic [5:0]  in_lz;
    fp_sign_t    s1_sign;
    word_t       s1_mag;
    logic [5:0]  s1_lz;

    // itof stage two
    shamt_t      norm_sh;
    word_t       norm;
    fp_exp_t     norm_exp;
    fp_frac_t    norm_frac;
    logic        guard;
    logic        sticky;
    logic        round_up;
    logic [30:0] rounded;

    // ftoi
    fp_sign_t    f_sign;
    fp_exp_t     f_exp;
    fp_frac_t    f_frac;
    shamt_t      f_rsh;
    word_t       f_mag;
    word_t       ftoi_c;

    assign in_sign = op1[31];
    // 0x80000000 stays correct as an unsigned magnitude
    assign in_mag  = in_sign ? word_t'(-op1) : op1;

    // leading zero count, 32 for zero input
    always_comb begin
        in_lz = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (in_mag[i]) begin
                in_lz = 6'(31 - i);
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_sign <= in_sign;
        s1_mag  <= in_mag;
        s1_lz   <= in_lz;
    end

    // leading one moved to bit 31
    assign norm_sh   = s1_lz[4:0];
    assign norm      = s1_mag << norm_sh;
    assign norm_exp  = exp_int_top - fp_exp_t'(s1_lz);
    assign norm_frac = norm[30:8];
    assign guard     = norm[7];
    assign sticky    = |norm[6:0];

    // nearest even, a frac carry bumps the exponent
    assign round_up = guard & (sticky | norm_frac[0]);
    assign rounded  = {norm_exp, norm_frac} + 31'(round_up);

    assign {f_sign, f_exp, f_frac} = op1;
    assign f_rsh = shamt_t'(exp_int_top - f_exp);
    assign f_mag = {1'b1, f_frac, 8'b0} >> f_rsh;

    always_comb begin
        if (f_exp == fp_exp_max && f_frac != '0) begin
            ftoi_c = int_max;
        end else if (f_exp < fp_exp_bias) begin
            // magnitude below one truncates to zero
            ftoi_c = '0;
        end else if (f_exp >= exp_int_top) begin
            ftoi_c = f_sign ? int_min : int_max;
        end else begin
            ftoi_c = f_sign ? word_t'(-f_mag) : f_mag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            itof <= '0;
            ftoi <= '0;
        end else begin
            // lz of 32 means a zero input
            itof <= s1_lz[5] ? '0 : {s1_sign, rounded};
            ftoi <= ftoi_c;
        end
    end

endmodule

/* logic/fp_compare.sv */
`timescale 1ns/10ps

module fp_compare
    import alu_types_pkg::*;
    import fp_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t op1,
    input  word_t op2,
    output word_t feq,
    output word_t flt,
    output word_t fle
);

    fp_sign_t sign_a;
    fp_sign_t sign_b;
    fp_exp_t  exp_a;
    fp_exp_t  exp_b;
    fp_frac_t frac_a;
    fp_frac_t frac_b;
    logic     nan_any;
    logic     both_zero;
    logic     eq_c;
    logic     lt_c;

    assign {sign_a, exp_a, frac_a} = op1;
    assign {sign_b, exp_b, frac_b} = op2;

    // any NaN makes the compare unordered
    assign nan_any = (exp_a == fp_exp_max && frac_a != '0)
                  || (exp_b == fp_exp_max && frac_b != '0);

    // +0 and -0 are equal
    assign both_zero = ({exp_a, frac_a} == '0) && ({exp_b, frac_b} == '0);

    assign eq_c = ~nan_any & (both_zero | (op1 == op2));

    always_comb begin
        if (nan_any || both_zero) begin
            lt_c = 1'b0;
        end else if (sign_a != sign_b) begin
            lt_c = sign_a;
        end else if (sign_a) begin
            // both negative, larger magnitude is smaller
            lt_c = {exp_a, frac_a} > {exp_b, frac_b};
        end else begin
            lt_c = {exp_a, frac_a} < {exp_b, frac_b};
        end
    end

    assign feq = word_t'(eq_c);

    always_ff @(posedge clk) begin
        if (rst) begin
            flt <= '0;
            fle <= '0;
        end else begin
            flt <= word_t'(lt_c);
            fle <= word_t'(lt_c | eq_c);
        end
    end

endmodule

/* logic/int_unit.sv */
`timescale 1ns/10ps

`include "alu_config.svh"

module int_unit
    import alu_types_pkg::*;
(
    input  word_t   op1,
    input  word_t   op2,
    input  alu_op_t op,
    output word_t   res
);

    shamt_t shamt;
    logic   lt_signed;
    logic   lt_unsigned;

    assign shamt = op2[`ALU_SHAMT_W-1:0];

    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    always_comb begin
        case (op)
            op_add, op_addi: res = op1 + op2;
            op_sub:          res = op1 - op2;
            op_slli:         res = op1 << shamt;
            op_srl:          res = op1 >> shamt;
            // arithmetic shift keeps the sign
            op_srai:         res = word_t'($signed(op1) >>> shamt);
            op_slt:          res = word_t'(lt_signed);
            op_sltu:         res = word_t'(lt_unsigned);
            op_xor:          res = op1 ^ op2;
            op_and:          res = op1 & op2;
            op_or:           res = op1 | op2;
            // immediate already shifted upstream
            op_lui:          res = op2;
            default:         res = '0;
        endcase
    end

endmodule

/* logic/fp_types_pkg.sv */
package fp_types_pkg;

    // single-precision fields, msb to lsb
    typedef logic       fp_sign_t;
    typedef logic [7:0] fp_exp_t;
    typedef logic [22:0] fp_frac_t;

    localparam fp_exp_t fp_exp_bias = 8'd127;

    // exponent of infinities and NaNs
    localparam fp_exp_t fp_exp_max = 8'hff;

    // canonical quiet NaN
    localparam logic [31:0] fp_qnan = 32'h7fc0_0000;

endpackage

/* logic/alu_types_pkg.sv */
package alu_types_pkg;

`include "alu_config.svh"

    typedef logic [`ALU_XLEN-1:0]    word_t;
    typedef logic [`ALU_SHAMT_W-1:0] shamt_t;
    typedef logic [`ALU_OP_W-1:0]    alu_op_t;

    // integer register-register ops
    localparam alu_op_t op_add   = 6'b000000;
    localparam alu_op_t op_sub   = 6'b000001;

    // float sign ops, compares, moves and conversions
    localparam alu_op_t op_fneg  = 6'b010101;
    localparam alu_op_t op_fabs  = 6'b010110;
    localparam alu_op_t op_feq   = 6'b011000;
    localparam alu_op_t op_flt   = 6'b011001;
    localparam alu_op_t op_fle   = 6'b011010;
    localparam alu_op_t op_fmvwx = 6'b011011;
    localparam alu_op_t op_fmvxw = 6'b011100;
    localparam alu_op_t op_fmv   = 6'b011101;
    localparam alu_op_t op_itof  = 6'b011110;
    localparam alu_op_t op_ftoi  = 6'b011111;

    // immediate forms and the rest of the integer set
    localparam alu_op_t op_addi  = 6'b100000;
    localparam alu_op_t op_slli  = 6'b100001;
    localparam alu_op_t op_srai  = 6'b100010;
    localparam alu_op_t op_srl   = 6'b100011;
    localparam alu_op_t op_slt   = 6'b100100;
    localparam alu_op_t op_sltu  = 6'b100101;
    localparam alu_op_t op_xor   = 6'b100110;
    localparam alu_op_t op_and   = 6'b100111;
    localparam alu_op_t op_or    = 6'b101000;
    localparam alu_op_t op_lui   = 6'b101010;

    // cycles from operands held to valid result
    typedef enum logic [1:0] {
        lat_zero = 2'd0,
        lat_one  = 2'd1,
        lat_two  = 2'd2
    } lat_class_t;

endpackage

/* logic/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// datapath word width
`define ALU_XLEN 32

// shift amount, low bits of op2
`define ALU_SHAMT_W 5

// width of the aluctl opcode field
`define ALU_OP_W 6

`endif
